//--- src/dbg_pkg.sv
// debug memory package
// address map, widths, abstract command types, error codes and instruction encoders

package dbg_pkg;

  // 12-bit offset into the debug memory window
  typedef logic [11:0] dbg_addr_t;
  // bus and instruction word
  typedef logic [31:0] word_t;

  // --------------------
  // address map
  // --------------------
  // mailboxes written by the hart
  localparam dbg_addr_t HaltedAddr    = 12'h100;
  localparam dbg_addr_t GoingAddr     = 12'h104;
  localparam dbg_addr_t ResumingAddr  = 12'h108;
  localparam dbg_addr_t ExceptionAddr = 12'h10C;
  // variable jump slot
  localparam dbg_addr_t WhereToAddr   = 12'h300;

  localparam int unsigned DataCount        = 2;
  localparam int unsigned ProgBufSize      = 8;
  localparam int unsigned AbstractCmdWords = 10;

  localparam dbg_addr_t DataAddr            = 12'h380;
  localparam dbg_addr_t DataEndAddr         = DataAddr + 12'(4 * DataCount) - 12'd1;
  localparam dbg_addr_t ProgBufBaseAddr     = DataAddr - 12'(4 * ProgBufSize);
  localparam dbg_addr_t ProgBufEndAddr      = DataAddr - 12'd1;
  localparam dbg_addr_t AbstractCmdBaseAddr = 12'h338;
  localparam dbg_addr_t AbstractCmdEndAddr  = ProgBufBaseAddr - 12'd1;
  // per-hart go and resume flags, one byte each
  localparam dbg_addr_t FlagsBaseAddr = 12'h400;
  localparam dbg_addr_t FlagsEndAddr  = 12'h7FF;
  // entry points of the hart into the debug window
  localparam dbg_addr_t HaltAddress   = 12'h800;
  localparam dbg_addr_t ResumeAddress = 12'h804;

  // largest aarsize plus one
  localparam int unsigned MaxAar = 3;
  localparam logic [11:0] CsrDscratch0 = 12'h7B2;

  // --------------------
  // abstract commands
  // --------------------
  typedef enum logic [7:0] {
    AccessRegister = 8'h0,
    QuickAccess    = 8'h1,
    AccessMemory   = 8'h2
  } cmdtype_e;

  typedef struct packed {
    logic        zero1;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_cmd_t;

  typedef struct packed {
    cmdtype_e    cmdtype;
    logic [23:0] control;
  } command_t;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4
  } cmderr_e;

  // hart-side memory bus, one master
  typedef struct packed {
    logic       req;
    logic       we;
    word_t      addr;
    word_t      wdata;
    logic [3:0] be;
  } bus_req_t;

  // --------------------
  // RV32 encoders
  // --------------------
  function automatic word_t jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // lb/lh/lw picked by size
  function automatic word_t load(logic [1:0] size, logic [4:0] dest, logic [4:0] base,
                                 logic [11:0] offset);
    return {offset, base, 1'b0, size, dest, 7'h03};
  endfunction

  // sb/sh/sw picked by size
  function automatic word_t store(logic [1:0] size, logic [4:0] src, logic [4:0] base,
                                  logic [11:0] offset);
    return {offset[11:5], src, base, 1'b0, size, offset[4:0], 7'h23};
  endfunction

  // csrrs dest, csr, x0
  function automatic word_t csrr(logic [11:0] csr, logic [4:0] dest);
    return {csr, 5'h0, 3'h2, dest, 7'h73};
  endfunction

  // csrrw x0, csr, rs1
  function automatic word_t csrw(logic [11:0] csr, logic [4:0] rs1);
    return {csr, rs1, 3'h1, 5'h0, 7'h73};
  endfunction

  function automatic word_t ebreak();
    return 32'h0010_0073;
  endfunction

  // addi x0, x0, 0
  function automatic word_t nop();
    return 32'h0000_0013;
  endfunction

  function automatic word_t illegal();
    return 32'h0000_0000;
  endfunction

endpackage

//--- src/hart_status.sv
// per-hart halted and resuming flags
// set from hart mailbox writes, cleared by the debugger or ndmreset

`timescale 1ns/1ps

module hart_status #(
  parameter int unsigned NrHarts = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ndmreset_i,
  input  logic [19:0]           hartsel_i,
  input  logic                  clear_resumeack_i,
  input  logic                  halted_wr_i,
  input  logic                  resuming_wr_i,
  input  logic [((NrHarts == 1) ? 1 : $clog2(NrHarts))-1:0] wr_hart_i,
  output logic [NrHarts-1:0]    halted_o,
  output logic [NrHarts-1:0]    resuming_o
);
  localparam int unsigned HartSelLen = (NrHarts == 1) ? 1 : $clog2(NrHarts);

  logic [HartSelLen-1:0] hartsel;
  logic [NrHarts-1:0]    halted_d, halted_q;
  logic [NrHarts-1:0]    resuming_d, resuming_q;

  assign hartsel    = hartsel_i[HartSelLen-1:0];
  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

  always_comb begin
    halted_d   = halted_q;
    resuming_d = resuming_q;
    for (int unsigned h = 0; h < NrHarts; h++) begin
      // debugger acknowledges the resume of the selected hart
      if (clear_resumeack_i && hartsel == HartSelLen'(h)) begin
        resuming_d[h] = 1'b0;
      end
      // hart writes win over the acknowledge
      if (wr_hart_i == HartSelLen'(h)) begin
        if (halted_wr_i) begin
          halted_d[h] = 1'b1;
        end
        if (resuming_wr_i) begin
          halted_d[h]   = 1'b0;
          resuming_d[h] = 1'b1;
        end
      end
    end
    if (ndmreset_i) begin
      halted_d   = '0;
      resuming_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

  // a hart that just announced its resume is no longer halted
  a_resume_clears_halt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resuming_wr_i |=> !(halted_q[$past(wr_hart_i)] && resuming_q[$past(wr_hart_i)]));

endmodule

//--- src/cmd_ctrl.sv
// command and resume FSM
// drives go, resume and busy, reports abstract command errors

`timescale 1ns/1ps

module cmd_ctrl import dbg_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [19:0]        hartsel_i,
  input  logic               cmd_valid_i,
  input  logic [NrHarts-1:0] haltreq_i,
  input  logic [NrHarts-1:0] resumereq_i,
  input  logic [NrHarts-1:0] halted_i,
  input  logic [NrHarts-1:0] resuming_i,
  input  logic               unsupported_i,
  input  logic               going_i,
  input  logic               exception_i,
  input  logic               halted_wr_i,
  output logic               go_o,
  output logic               resume_o,
  output logic               cmdbusy_o,
  output logic               cmderror_valid_o,
  output cmderr_e            cmderror_o
);
  localparam int unsigned HartSelLen     = (NrHarts == 1) ? 1 : $clog2(NrHarts);
  localparam int unsigned NrHartsAligned = 2**HartSelLen;

  typedef enum logic [1:0] {Idle, Go, Resume, CmdExecuting} state_e;
  state_e state_d, state_q;

  logic [HartSelLen-1:0]     hartsel;
  logic [NrHartsAligned-1:0] halted, resuming, haltreq, resumereq;

  // pad to a power of two so hartsel never indexes out of range
  assign hartsel   = hartsel_i[HartSelLen-1:0];
  assign halted    = NrHartsAligned'(halted_i);
  assign resuming  = NrHartsAligned'(resuming_i);
  assign haltreq   = NrHartsAligned'(haltreq_i);
  assign resumereq = NrHartsAligned'(resumereq_i);

  always_comb begin
    state_d          = state_q;
    go_o             = 1'b0;
    resume_o         = 1'b0;
    cmdbusy_o        = 1'b1;
    cmderror_valid_o = 1'b0;
    cmderror_o       = CmdErrNone;
    unique case (state_q)
      Idle: begin
        cmdbusy_o = 1'b0;
        if (cmd_valid_i && halted[hartsel] && !unsupported_i) begin
          state_d = Go;
        end else if (cmd_valid_i) begin
          // commands need a halted hart
          cmderror_valid_o = 1'b1;
          cmderror_o       = CmdErrHaltResume;
        end
        // resume only a halted hart that has acked its last resume
        if (resumereq[hartsel] && !resuming[hartsel] && !haltreq[hartsel] &&
            halted[hartsel]) begin
          state_d = Resume;
        end
      end
      Go: begin
        go_o = 1'b1;
        // hart picked up the program
        if (going_i) begin
          state_d = CmdExecuting;
        end
      end
      Resume: begin
        resume_o = 1'b1;
        if (resuming[hartsel]) begin
          state_d = Idle;
        end
      end
      CmdExecuting: begin
        // back in the park loop, command done
        if (halted_wr_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase

    // reported once, on the strobe
    if (cmd_valid_i && unsupported_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrNotSupported;
    end
    // exception outranks everything
    if (exception_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = CmdErrException;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  a_go_resume_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(go_o && resume_o));

endmodule

//--- src/abstract_cmd_gen.sv
// abstract command program generator
// ten-word Access Register program for GPR and CSR transfers

`timescale 1ns/1ps

module abstract_cmd_gen import dbg_pkg::*; (
  input  command_t                     cmd_i,
  output word_t [AbstractCmdWords-1:0] prog_o,
  output logic                         unsupported_o
);
  // s0 is the scratch register for CSR moves
  localparam logic [4:0] S0 = 5'd8;

  ac_ar_cmd_t ac_ar;

  assign ac_ar = ac_ar_cmd_t'(cmd_i.control);

  always_comb begin
    unsupported_o = 1'b0;
    // --------------------
    // default program
    // --------------------
    // word 0 traps if the hart lands here without a transfer
    prog_o[0] = illegal();
    for (int unsigned i = 1; i < AbstractCmdWords - 1; i++) begin
      prog_o[i] = nop();
    end
    prog_o[AbstractCmdWords-1] = ebreak();

    if (cmd_i.cmdtype != AccessRegister || 32'(ac_ar.aarsize) >= MaxAar ||
        ac_ar.aarpostincrement || ac_ar.regno[15:14] != 2'b00) begin
      // leave straight away
      unsupported_o = 1'b1;
      prog_o[0]     = ebreak();
    end else if (ac_ar.transfer) begin
      prog_o[0] = nop();
      if (ac_ar.regno[12]) begin
        // --------------------
        // GPR
        // --------------------
        // write means data register into the GPR
        if (ac_ar.write) begin
          prog_o[2] = load(ac_ar.aarsize[1:0], ac_ar.regno[4:0], 5'd0, DataAddr);
        end else begin
          prog_o[2] = store(ac_ar.aarsize[1:0], ac_ar.regno[4:0], 5'd0, DataAddr);
        end
      end else begin
        // --------------------
        // CSR
        // --------------------
        // save s0, move through it, restore it
        prog_o[2] = csrw(CsrDscratch0, S0);
        if (ac_ar.write) begin
          prog_o[3] = load(ac_ar.aarsize[1:0], S0, 5'd0, DataAddr);
          prog_o[4] = csrw(ac_ar.regno[11:0], S0);
        end else begin
          prog_o[3] = csrr(ac_ar.regno[11:0], S0);
          prog_o[4] = store(ac_ar.aarsize[1:0], S0, 5'd0, DataAddr);
        end
        prog_o[5] = csrr(CsrDscratch0, S0);
      end
    end

    // fall through into the program buffer
    if (ac_ar.postexec && !unsupported_o) begin
      prog_o[AbstractCmdWords-1] = nop();
    end
  end

endmodule

//--- src/mem_decode.sv
// hart bus decode
// mailbox strobes, data register merge and the registered read mux

`timescale 1ns/1ps

module mem_decode import dbg_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  bus_req_t                     bus_i,
  input  logic [19:0]                  hartsel_i,
  input  logic [NrHarts-1:0]           resumereq_i,
  input  command_t                     cmd_i,
  input  logic                         cmdbusy_i,
  input  logic                         go_i,
  input  logic                         resume_i,
  input  word_t [AbstractCmdWords-1:0] prog_i,
  input  word_t [ProgBufSize-1:0]      progbuf_i,
  input  word_t [DataCount-1:0]        data_i,
  output word_t                        rdata_o,
  output word_t [DataCount-1:0]        data_o,
  output logic                         data_valid_o,
  output logic                         halted_wr_o,
  output logic                         resuming_wr_o,
  output logic [((NrHarts == 1) ? 1 : $clog2(NrHarts))-1:0] wr_hart_o,
  output logic                         going_o,
  output logic                         exception_o
);
  localparam int unsigned HartSelLen     = (NrHarts == 1) ? 1 : $clog2(NrHarts);
  localparam int unsigned NrHartsAligned = 2**HartSelLen;
  localparam int unsigned DataIdxW       = (DataCount > 1) ? $clog2(DataCount) : 1;
  localparam int unsigned ProgBufIdxW    = $clog2(ProgBufSize);
  localparam int unsigned AbsIdxW        = $clog2(AbstractCmdWords);

  dbg_addr_t                 addr, hart_off, flag_off;
  logic [HartSelLen-1:0]     hartsel;
  logic [NrHartsAligned-1:0] resumereq;
  logic [DataIdxW-1:0]       data_idx;
  logic [ProgBufIdxW-1:0]    pb_idx;
  logic [AbsIdxW-1:0]        ac_idx;
  logic [3:0][7:0]           flag_bytes;
  ac_ar_cmd_t                ac_ar;
  word_t                     rdata_d, rdata_q;

  assign addr      = bus_i.addr[11:0];
  assign hartsel   = hartsel_i[HartSelLen-1:0];
  assign resumereq = NrHartsAligned'(resumereq_i);
  assign wr_hart_o = bus_i.wdata[HartSelLen-1:0];
  assign ac_ar     = ac_ar_cmd_t'(cmd_i.control);
  assign rdata_o   = rdata_q;

  // word index inside each window
  assign data_idx = DataIdxW'(addr[11:2] - DataAddr[11:2]);
  assign pb_idx   = ProgBufIdxW'(addr[11:2] - ProgBufBaseAddr[11:2]);
  assign ac_idx   = AbsIdxW'(addr[11:2] - AbstractCmdBaseAddr[11:2]);
  // flags word of the polling hart, byte offsets from the flags base
  assign hart_off = dbg_addr_t'(hartsel);
  assign flag_off = {addr[11:2], 2'b00} - FlagsBaseAddr;

  // --------------------
  // writes
  // --------------------
  always_comb begin
    halted_wr_o   = 1'b0;
    resuming_wr_o = 1'b0;
    going_o       = 1'b0;
    exception_o   = 1'b0;
    data_valid_o  = 1'b0;
    data_o        = data_i;
    if (bus_i.req && bus_i.we) begin
      unique case (addr) inside
        HaltedAddr:    halted_wr_o   = 1'b1;
        GoingAddr:     going_o       = 1'b1;
        ResumingAddr:  resuming_wr_o = 1'b1;
        ExceptionAddr: exception_o   = 1'b1;
        [DataAddr:DataEndAddr]: begin
          data_valid_o = 1'b1;
          // byte merge over the debugger's copy
          for (int unsigned i = 0; i < 4; i++) begin
            if (bus_i.be[i]) begin
              data_o[data_idx][i*8 +: 8] = bus_i.wdata[i*8 +: 8];
            end
          end
        end
        default: ;
      endcase
    end
  end

  // --------------------
  // reads
  // --------------------
  always_comb begin
    flag_bytes = '0;
    rdata_d    = rdata_q;
    if (bus_i.req && !bus_i.we) begin
      unique case (addr) inside
        WhereToAddr: begin
          rdata_d = '0;
          if (resumereq[hartsel]) begin
            rdata_d = jal(5'd0, 21'(ResumeAddress - WhereToAddr));
          end
          // a running command overrides the resume jump
          if (cmdbusy_i) begin
            if (cmd_i.cmdtype == AccessRegister && !ac_ar.transfer && ac_ar.postexec) begin
              rdata_d = jal(5'd0, 21'(ProgBufBaseAddr - WhereToAddr));
            end else begin
              rdata_d = jal(5'd0, 21'(AbstractCmdBaseAddr - WhereToAddr));
            end
          end
        end
        [DataAddr:DataEndAddr]:                   rdata_d = data_i[data_idx];
        [ProgBufBaseAddr:ProgBufEndAddr]:         rdata_d = progbuf_i[pb_idx];
        [AbstractCmdBaseAddr:AbstractCmdEndAddr]: rdata_d = prog_i[ac_idx];
        [FlagsBaseAddr:FlagsEndAddr]: begin
          // only the selected hart sees go and resume
          if (flag_off == {hart_off[11:2], 2'b00}) begin
            flag_bytes[hart_off[1:0]] = {6'b0, resume_i, go_i};
          end
          rdata_d = flag_bytes;
        end
        // no ROM behind the halt address
        [HaltAddress:12'hFFF]: rdata_d = '0;
        default:               rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

endmodule

//--- src/dbg_mem.sv
// debug memory top level
// hart bookkeeping, command FSM, program generator and bus decode

`timescale 1ns/1ps

module dbg_mem import dbg_pkg::*; #(
  parameter int unsigned NrHarts = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ndmreset_i,
  // hart bus
  input  bus_req_t                bus_i,
  output word_t                   rdata_o,
  // run control
  input  logic [19:0]             hartsel_i,
  input  logic [NrHarts-1:0]      haltreq_i,
  input  logic [NrHarts-1:0]      resumereq_i,
  input  logic                    clear_resumeack_i,
  output logic [NrHarts-1:0]      debug_req_o,
  output logic [NrHarts-1:0]      halted_o,
  output logic [NrHarts-1:0]      resuming_o,
  // program buffer and data registers
  input  word_t [ProgBufSize-1:0] progbuf_i,
  input  word_t [DataCount-1:0]   data_i,
  output word_t [DataCount-1:0]   data_o,
  output logic                    data_valid_o,
  // abstract commands
  input  logic                    cmd_valid_i,
  input  command_t                cmd_i,
  output logic                    cmderror_valid_o,
  output cmderr_e                 cmderror_o,
  output logic                    cmdbusy_o
);
  localparam int unsigned HartSelLen = (NrHarts == 1) ? 1 : $clog2(NrHarts);

  logic                         halted_wr, resuming_wr, going, exception;
  logic [HartSelLen-1:0]        wr_hart;
  logic                         go, resume, unsupported;
  word_t [AbstractCmdWords-1:0] prog;

  // halt requests go straight to the harts
  assign debug_req_o = haltreq_i;

  hart_status #(
    .NrHarts (NrHarts)
  ) u_hart_status (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ndmreset_i        (ndmreset_i),
    .hartsel_i         (hartsel_i),
    .clear_resumeack_i (clear_resumeack_i),
    .halted_wr_i       (halted_wr),
    .resuming_wr_i     (resuming_wr),
    .wr_hart_i         (wr_hart),
    .halted_o          (halted_o),
    .resuming_o        (resuming_o)
  );

  cmd_ctrl #(
    .NrHarts (NrHarts)
  ) u_cmd_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .hartsel_i        (hartsel_i),
    .cmd_valid_i      (cmd_valid_i),
    .haltreq_i        (haltreq_i),
    .resumereq_i      (resumereq_i),
    .halted_i         (halted_o),
    .resuming_i       (resuming_o),
    .unsupported_i    (unsupported),
    .going_i          (going),
    .exception_i      (exception),
    .halted_wr_i      (halted_wr),
    .go_o             (go),
    .resume_o         (resume),
    .cmdbusy_o        (cmdbusy_o),
    .cmderror_valid_o (cmderror_valid_o),
    .cmderror_o       (cmderror_o)
  );

  abstract_cmd_gen u_abstract_cmd_gen (
    .cmd_i         (cmd_i),
    .prog_o        (prog),
    .unsupported_o (unsupported)
  );

  mem_decode #(
    .NrHarts (NrHarts)
  ) u_mem_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus_i         (bus_i),
    .hartsel_i     (hartsel_i),
    .resumereq_i   (resumereq_i),
    .cmd_i         (cmd_i),
    .cmdbusy_i     (cmdbusy_o),
    .go_i          (go),
    .resume_i      (resume),
    .prog_i        (prog),
    .progbuf_i     (progbuf_i),
    .data_i        (data_i),
    .rdata_o       (rdata_o),
    .data_o        (data_o),
    .data_valid_o  (data_valid_o),
    .halted_wr_o   (halted_wr),
    .resuming_wr_o (resuming_wr),
    .wr_hart_o     (wr_hart),
    .going_o       (going),
    .exception_o   (exception)
  );

endmodule

//--- bench/tb_dbg_mem.sv
// testbench for the debug memory core
// replays the stimulus records and compares DUT responses with the expected columns

`timescale 1ns/1ps

module tb_dbg_mem import dbg_pkg::*; ();

  localparam int unsigned NrHarts    = 4;
  localparam int unsigned RecIdxW    = 7;
  localparam int unsigned MaxRecords = 2**RecIdxW;
  // generous budget per record, most take one or two cycles
  localparam int unsigned CyclesPerRecord = 40;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    ndmreset;
  bus_req_t                bus;
  word_t                   rdata;
  logic [19:0]             hartsel;
  logic [NrHarts-1:0]      haltreq, resumereq, debug_req, halted, resuming;
  logic                    clear_resumeack;
  word_t [ProgBufSize-1:0] progbuf;
  word_t [DataCount-1:0]   data_in, data_out;
  logic                    data_valid;
  logic                    cmd_valid;
  command_t                cmd;
  logic                    cmderror_valid;
  cmderr_e                 cmderror;
  logic                    cmdbusy;

  // one record per line, op a b c d
  logic [127:0] stim_mem [MaxRecords];

  int unsigned cycle_cnt, cycle_limit;
  int unsigned checks, errors, tests, test_errors;

  dbg_mem #(
    .NrHarts (NrHarts)
  ) dut0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ndmreset_i        (ndmreset),
    .bus_i             (bus),
    .rdata_o           (rdata),
    .hartsel_i         (hartsel),
    .haltreq_i         (haltreq),
    .resumereq_i       (resumereq),
    .clear_resumeack_i (clear_resumeack),
    .debug_req_o       (debug_req),
    .halted_o          (halted),
    .resuming_o        (resuming),
    .progbuf_i         (progbuf),
    .data_i            (data_in),
    .data_o            (data_out),
    .data_valid_o      (data_valid),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .cmderror_valid_o  (cmderror_valid),
    .cmderror_o        (cmderror),
    .cmdbusy_o         (cmdbusy)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  // --------------------
  // timeout
  // --------------------
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    int unsigned idx;
    logic [127:0] rec;
    logic [7:0]   op;
    logic [23:0]  fa;
    logic [31:0]  fb, fc, fd;
    logic [0:0]   didx;

    checks          = 0;
    errors          = 0;
    tests           = 0;
    test_errors     = 0;
    cycle_cnt       = 0;
    cycle_limit     = 0;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    ndmreset        = 1'b0;
    bus             = '0;
    hartsel         = '0;
    haltreq         = '0;
    resumereq       = '0;
    clear_resumeack = 1'b0;
    cmd_valid       = 1'b0;
    cmd             = '0;
    // fill words carry their own debug address
    for (idx = 0; idx < ProgBufSize; idx++) begin
      progbuf[3'(idx)] = {20'hB0F00, 12'h360 + 12'(4 * idx)};
    end
    data_in[0] = {20'hDA7A0, 12'h380};
    data_in[1] = {20'hDA7A0, 12'h384};

    // unused slots read as the end marker
    for (idx = 0; idx < MaxRecords; idx++) begin
      stim_mem[idx[RecIdxW-1:0]] = '1;
    end
    $readmemh("bench/dbg_stim.txt", stim_mem);
    idx = 0;
    while (idx < MaxRecords && stim_mem[idx[RecIdxW-1:0]][127:120] != 8'hff) begin
      idx++;
    end
    if (idx == 0) begin
      $display("no stimulus records were loaded");
      errors++;
    end
    cycle_limit = CyclesPerRecord * (idx + 10);

    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int unsigned r = 0; r < idx; r++) begin
      rec = stim_mem[r[RecIdxW-1:0]];
      op  = rec[127:120];
      fa  = rec[119:96];
      fb  = rec[95:64];
      fc  = rec[63:32];
      fd  = rec[31:0];
      case (op)
        // mailbox write, error outputs sampled mid cycle
        8'h01: begin
          bus = '{req: 1'b1, we: 1'b1, addr: 32'(fa), wdata: fb, be: fc[3:0]};
          #2;
          check_value("cmderror", 32'({cmderror_valid, cmderror}), 32'(fd[3:0]));
          next_cycle();
          bus = '0;
        end
        // read, data shows up after the next edge
        8'h02: begin
          bus = '{req: 1'b1, we: 1'b0, addr: 32'(fa), wdata: '0, be: 4'h0};
          next_cycle();
          bus = '0;
          check_value("rdata", rdata, fc);
        end
        8'h03: begin
          cmd       = command_t'(fb);
          cmd_valid = 1'b1;
          #2;
          check_value("cmderror", 32'({cmderror_valid, cmderror}), 32'(fd[3:0]));
          next_cycle();
          cmd_valid = 1'b0;
        end
        8'h04: begin
          hartsel         = fa[19:0];
          resumereq       = fb[3:0];
          haltreq         = fb[7:4];
          clear_resumeack = fb[8];
          ndmreset        = fb[9];
          // halt requests pass straight through to the harts
          #2;
          check_value("debug_req", 32'(debug_req), 32'(fb[7:4]));
          next_cycle();
        end
        8'h05: begin
          check_value("halted", 32'(halted), 32'(fc[3:0]));
          check_value("resuming", 32'(resuming), 32'(fc[7:4]));
          check_value("cmdbusy", 32'(cmdbusy), 32'(fc[8]));
          next_cycle();
        end
        // data window write, merged word visible in the same cycle
        8'h06: begin
          didx = fa[2];
          bus  = '{req: 1'b1, we: 1'b1, addr: 32'(fa), wdata: fb, be: fc[3:0]};
          #2;
          check_value("data_valid", 32'(data_valid), 32'h1);
          check_value("data_o", data_out[didx], fd);
          next_cycle();
          bus = '0;
        end
        8'h0e: begin
          tests++;
          if (test_errors == 0) begin
            $display("test %0d ok", fa);
          end else begin
            $display("test %0d: %0d mismatches", fa, test_errors);
          end
          test_errors = 0;
        end
        default: begin
          $display("unknown opcode %h in stimulus record %0d", op, r);
          errors++;
        end
      endcase
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
src/dbg_pkg.sv
src/hart_status.sv
src/cmd_ctrl.sv
src/abstract_cmd_gen.sv
src/mem_decode.sv
src/dbg_mem.sv
bench/tb_dbg_mem.sv

//--- Makefile
# Verilator build and run for the debug memory testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, grep the log for the result"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/Vtb_dbg_mem: compile.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module tb_dbg_mem -f compile.f -o Vtb_dbg_mem

test: obj_dir/Vtb_dbg_mem
	./obj_dir/Vtb_dbg_mem | tee sim.log
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/dbg_stim.txt
// op_a_b_c_d: 01 write a=addr b=wdata c=be d=cmderror, 02 read c=rdata, 03 cmd b d=cmderror
// 04 levels a=hartsel b=ndm/clrack/haltreq/resumereq, 05 c=busy/resuming/halted, 06 data write d=data_o, 0e end of test a
// 1 halt handshake
05_000000_00000000_00000000_00000000
04_000002_00000000_00000000_00000000
01_000100_00000002_0000000f_00000000
05_000000_00000000_00000004_00000000
02_000400_00000000_00000000_00000000
04_000001_00000000_00000000_00000000
03_000000_00221005_00000000_0000000c
04_000002_00000000_00000000_00000000
05_000000_00000000_00000004_00000000
0e_000001_00000000_00000000_00000000
// 2 read x5, size 2
03_000000_00221005_00000000_00000000
05_000000_00000000_00000104_00000000
02_000400_00000000_00010000_00000000
02_000300_00000000_0380006f_00000000
02_000340_00000000_38502023_00000000
01_000104_00000002_0000000f_00000000
05_000000_00000000_00000104_00000000
02_000400_00000000_00000000_00000000
01_000100_00000002_0000000f_00000000
05_000000_00000000_00000004_00000000
0e_000002_00000000_00000000_00000000
// 3 unsupported, postexec only, CSR write
03_000000_00321005_00000000_0000000a
05_000000_00000000_00000004_00000000
03_000000_00240000_00000000_00000000
05_000000_00000000_00000104_00000000
02_000300_00000000_0600006f_00000000
01_000104_00000002_0000000f_00000000
01_000100_00000002_0000000f_00000000
05_000000_00000000_00000004_00000000
03_000000_00230300_00000000_00000000
02_000340_00000000_7b241073_00000000
02_000344_00000000_38002403_00000000
02_000348_00000000_30041073_00000000
02_00034c_00000000_7b202473_00000000
01_000104_00000002_0000000f_00000000
01_000100_00000002_0000000f_00000000
05_000000_00000000_00000004_00000000
0e_000003_00000000_00000000_00000000
// 4 data registers and program buffer
06_000380_1234abcd_00000003_da7aabcd
06_000384_55667788_0000000c_55660384
02_000380_00000000_da7a0380_00000000
02_000384_00000000_da7a0384_00000000
02_000360_00000000_b0f00360_00000000
02_00037c_00000000_b0f0037c_00000000
0e_000004_00000000_00000000_00000000
// 5 resume
04_000002_00000044_00000000_00000000
05_000000_00000000_00000004_00000000
02_000300_00000000_5040006f_00000000
04_000002_00000004_00000000_00000000
02_000400_00000000_00020000_00000000
01_000108_00000002_0000000f_00000000
05_000000_00000000_00000140_00000000
05_000000_00000000_00000040_00000000
04_000002_00000100_00000000_00000000
04_000002_00000000_00000000_00000000
05_000000_00000000_00000000_00000000
0e_000005_00000000_00000000_00000000
// 6 exception
01_000100_00000002_0000000f_00000000
05_000000_00000000_00000004_00000000
03_000000_00221005_00000000_00000000
01_000104_00000002_0000000f_00000000
01_00010c_00000002_0000000f_0000000b
01_000100_00000002_0000000f_00000000
05_000000_00000000_00000004_00000000
0e_000006_00000000_00000000_00000000
